// ==== src/accel_pkg.sv ====
/* Shared widths, opcodes, FSM states and bus structs of the accelerator.
   Every module imports it with accel_pkg::* in its header. */
package accel_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;
  localparam int LEN_W  = 8;
  localparam int TAG_W  = 4;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_SUM = 3'd4,   // Reduction engine
    OP_MAX = 3'd5
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_IDLE, ALU_READ_A, ALU_READ_B, ALU_WRITE, ALU_DONE
  } alu_state_e;

  typedef enum logic [1:0] {
    RED_IDLE, RED_READ, RED_WRITE, RED_DONE
  } red_state_e;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    opcode_e           op;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] src_a;
    logic [ADDR_W-1:0] src_b;   // Unused by reductions
    logic [ADDR_W-1:0] dst;
    logic [LEN_W-1:0]  len;
  } cmd_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             engine;   // 0 vector, 1 reduction
  } cpl_t;

endpackage

// ==== src/std_mem_d1.sv ====
/* Single-port word memory with combinational read.
   done pulses the cycle after a write; out-of-range accesses are harmless. */
`timescale 1ns/1ps

module std_mem_d1
  import accel_pkg::*;
#(
  parameter int MEM_SIZE = 256
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] addr0,
  input  logic [DATA_W-1:0] write_data,
  input  logic              write_en,
  output logic [DATA_W-1:0] read_data,
  output logic              done
);

  logic [DATA_W-1:0] mem [MEM_SIZE];
  logic              in_range;

  assign in_range  = (addr0 < MEM_SIZE);
  assign read_data = in_range ? mem[addr0] : '0;

  always_ff @(posedge clk) begin
    if (reset)
      done <= 1'b0;
    else
      done <= write_en;
  end

  // Writes past the end are dropped
  always_ff @(posedge clk) begin
    if (!reset && write_en && in_range)
      mem[addr0] <= write_data;
  end

endmodule

// ==== src/mem_arbiter.sv ====
/* Round-robin arbiter for the scratch memory.
   Grants one of host, vector and reduction requesters per cycle. */
`timescale 1ns/1ps

module mem_arbiter
  import accel_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     host_valid,
  input  logic     alu_valid,
  input  logic     red_valid,
  input  mem_req_t host_req,
  input  mem_req_t alu_req,
  input  mem_req_t red_req,
  output logic     host_grant,
  output logic     alu_grant,
  output logic     red_grant,
  output mem_req_t mem_req,
  output logic     mem_write_en
);

  logic [2:0] valid_vec;
  logic [2:0] grant_vec;
  logic [1:0] ptr;   // Requester with highest priority
  logic [1:0] win;
  logic [1:0] idx;
  logic       any;

  assign valid_vec = {red_valid, alu_valid, host_valid};

  // Search starting at the pointer, wrapping after requester 2
  always_comb begin
    any = 1'b0;
    win = ptr;
    idx = ptr;
    for (int i = 0; i < 3; i++) begin
      if (!any && valid_vec[idx]) begin
        any = 1'b1;
        win = idx;
      end
      idx = (idx == 2'd2) ? 2'd0 : idx + 2'd1;
    end
  end

  assign grant_vec = any ? (3'b001 << win) : 3'b000;
  assign {red_grant, alu_grant, host_grant} = grant_vec;

  always_comb begin
    case (win)
      2'd0:    mem_req = host_req;
      2'd1:    mem_req = alu_req;
      default: mem_req = red_req;
    endcase
  end

  assign mem_write_en = any && mem_req.we;

  always_ff @(posedge clk) begin
    if (reset)
      ptr <= 2'd0;
    else if (any)
      ptr <= (win == 2'd2) ? 2'd0 : win + 2'd1;   // Move past the winner
  end

endmodule

// ==== src/vec_alu_engine.sv ====
/* Elementwise vector engine, dst[i] = a[i] op b[i].
   Started by the dispatcher; holds done until it is acknowledged. */
`timescale 1ns/1ps

module vec_alu_engine
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  cmd_t              cmd,
  output logic              busy,
  output logic              done,
  input  logic              done_ack,
  output logic              req_valid,
  output mem_req_t          req,
  input  logic              grant,
  input  logic [DATA_W-1:0] rdata,
  output logic [TAG_W-1:0]  tag
);

  alu_state_e        state;
  cmd_t              cur;
  logic [LEN_W-1:0]  idx;
  logic [LEN_W-1:0]  idx_next;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] result;

  function automatic logic [DATA_W-1:0] alu_op(input opcode_e op,
                                               input logic [DATA_W-1:0] a,
                                               input logic [DATA_W-1:0] b);
    case (op)
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return a + b;
    endcase
  endfunction

  assign idx_next = idx + 1'b1;

  // FSM --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ALU_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        ALU_IDLE: begin
          if (start) begin
            idx   <= '0;
            state <= (cmd.len == '0) ? ALU_DONE : ALU_READ_A;
          end
        end
        ALU_READ_A: begin
          if (grant)
            state <= ALU_READ_B;
        end
        ALU_READ_B: begin
          if (grant)
            state <= ALU_WRITE;
        end
        ALU_WRITE: begin
          if (grant) begin
            idx   <= idx_next;
            state <= (idx_next == cur.len) ? ALU_DONE : ALU_READ_A;
          end
        end
        ALU_DONE: begin
          if (done_ack)
            state <= ALU_IDLE;
        end
        default: state <= ALU_IDLE;
      endcase
    end
  end

  // Operands and result
  always_ff @(posedge clk) begin
    if (state == ALU_IDLE && start)
      cur <= cmd;
    if (state == ALU_READ_A && grant)
      op_a <= rdata;
    if (state == ALU_READ_B && grant)
      result <= alu_op(cur.op, op_a, rdata);
  end

  // Memory request --------------------
  always_comb begin
    req_valid = 1'b0;
    req       = '0;
    case (state)
      ALU_READ_A: begin
        req_valid = 1'b1;
        req.addr  = cur.src_a + ADDR_W'(idx);
      end
      ALU_READ_B: begin
        req_valid = 1'b1;
        req.addr  = cur.src_b + ADDR_W'(idx);
      end
      ALU_WRITE: begin
        req_valid = 1'b1;
        req.we    = 1'b1;
        req.addr  = cur.dst + ADDR_W'(idx);
        req.wdata = result;
      end
      default: ;
    endcase
  end

  assign busy = (state != ALU_IDLE);
  assign done = (state == ALU_DONE);
  assign tag  = cur.tag;

endmodule

// ==== src/vec_reduce_engine.sv ====
/* Reduction engine writing the sum or unsigned maximum of a vector
   to a single destination word. */
`timescale 1ns/1ps

module vec_reduce_engine
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  cmd_t              cmd,
  output logic              busy,
  output logic              done,
  input  logic              done_ack,
  output logic              req_valid,
  output mem_req_t          req,
  input  logic              grant,
  input  logic [DATA_W-1:0] rdata,
  output logic [TAG_W-1:0]  tag
);

  red_state_e        state;
  cmd_t              cur;
  logic [LEN_W-1:0]  idx;
  logic [LEN_W-1:0]  idx_next;
  logic [DATA_W-1:0] acc;

  function automatic logic [DATA_W-1:0] reduce_op(input opcode_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] x);
    if (op == OP_MAX)
      return (x > a) ? x : a;
    return a + x;   // Wraps at 32 bits
  endfunction

  assign idx_next = idx + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RED_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        RED_IDLE: begin
          if (start) begin
            idx   <= '0;
            state <= (cmd.len == '0) ? RED_DONE : RED_READ;
          end
        end
        RED_READ: begin
          if (grant) begin
            idx   <= idx_next;
            state <= (idx_next == cur.len) ? RED_WRITE : RED_READ;
          end
        end
        RED_WRITE: begin
          if (grant)
            state <= RED_DONE;
        end
        default: begin
          if (done_ack)
            state <= RED_IDLE;
        end
      endcase
    end
  end

  // Accumulator seeded with 0 for a sum, first element for a max
  always_ff @(posedge clk) begin
    if (state == RED_IDLE && start) begin
      cur <= cmd;
      acc <= '0;
    end
    if (state == RED_READ && grant) begin
      if (cur.op == OP_MAX && idx == '0)
        acc <= rdata;
      else
        acc <= reduce_op(cur.op, acc, rdata);
    end
  end

  assign req_valid = (state == RED_READ) || (state == RED_WRITE);
  assign req.we    = (state == RED_WRITE);
  assign req.addr  = (state == RED_WRITE) ? cur.dst : cur.src_a + ADDR_W'(idx);
  assign req.wdata = acc;

  assign busy = (state != RED_IDLE);
  assign done = (state == RED_DONE);
  assign tag  = cur.tag;

endmodule

// ==== src/cmd_dispatch.sv ====
/* In-order command queue with credit return, opcode routing to the
   two engines, and merging of their done signals into completions. */
`timescale 1ns/1ps

module cmd_dispatch
  import accel_pkg::*;
#(
  parameter int CMD_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmd_valid,
  input  cmd_t             cmd,
  output logic             cmd_credit,
  output logic             alu_start,
  output logic             red_start,
  output cmd_t             dispatch_cmd,
  input  logic             alu_busy,
  input  logic             red_busy,
  input  logic             alu_done,
  input  logic             red_done,
  input  logic [TAG_W-1:0] alu_tag,
  input  logic [TAG_W-1:0] red_tag,
  output logic             alu_ack,
  output logic             red_ack,
  output logic             cpl_valid,
  output cpl_t             cpl
);

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  cmd_t             queue [CMD_DEPTH];
  cmd_t             head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             head_is_red;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Queue --------------------
  assign full  = (count == CNT_W'(CMD_DEPTH));
  assign empty = (count == '0);
  assign push  = cmd_valid && !full;

  always_ff @(posedge clk) begin
    if (push)
      queue[wr_ptr] <= cmd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Head waits for its own engine
  assign head        = queue[rd_ptr];
  assign head_is_red = (head.op == OP_SUM) || (head.op == OP_MAX);
  assign pop         = !empty && (head_is_red ? !red_busy : !alu_busy);

  assign alu_start    = pop && !head_is_red;
  assign red_start    = pop && head_is_red;
  assign dispatch_cmd = head;
  assign cmd_credit   = pop;   // One credit back per dispatch

  // Completions --------------------
  assign alu_ack = alu_done;
  assign red_ack = red_done && !alu_done;   // Vector engine first

  always_ff @(posedge clk) begin
    if (reset)
      cpl_valid <= 1'b0;
    else
      cpl_valid <= alu_ack || red_ack;
  end

  always_ff @(posedge clk) begin
    if (alu_ack)
      cpl <= '{tag: alu_tag, engine: 1'b0};
    else if (red_ack)
      cpl <= '{tag: red_tag, engine: 1'b1};
  end

endmodule

// ==== src/accel_top.sv ====
/* Accelerator top level: command dispatcher, vector and reduction engines,
   and the host port sharing one scratch memory through the arbiter. */
`timescale 1ns/1ps

module accel_top
  import accel_pkg::*;
#(
  parameter int MEM_SIZE  = 256,
  parameter int CMD_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,
  input  cmd_t              cmd,
  output logic              cmd_credit,
  output logic              cpl_valid,
  output cpl_t              cpl,
  input  logic              host_valid,
  input  mem_req_t          host_req,
  output logic              host_grant,
  output logic [DATA_W-1:0] host_rdata,
  output logic              host_wdone
);

  cmd_t              dispatch_cmd;
  logic              alu_start;
  logic              alu_busy;
  logic              alu_done;
  logic              alu_ack;
  logic [TAG_W-1:0]  alu_tag;
  logic              alu_valid;
  logic              alu_grant;
  mem_req_t          alu_req;
  logic              red_start;
  logic              red_busy;
  logic              red_done;
  logic              red_ack;
  logic [TAG_W-1:0]  red_tag;
  logic              red_valid;
  logic              red_grant;
  mem_req_t          red_req;
  mem_req_t          mem_req;
  logic              mem_write_en;
  logic [DATA_W-1:0] mem_rdata;

  cmd_dispatch #(.CMD_DEPTH(CMD_DEPTH)) u_dispatch (
    .clk, .reset, .cmd_valid, .cmd, .cmd_credit,
    .alu_start, .red_start, .dispatch_cmd,
    .alu_busy, .red_busy, .alu_done, .red_done, .alu_tag, .red_tag,
    .alu_ack, .red_ack, .cpl_valid, .cpl
  );

  vec_alu_engine u_alu (
    .clk, .reset, .start(alu_start), .cmd(dispatch_cmd),
    .busy(alu_busy), .done(alu_done), .done_ack(alu_ack),
    .req_valid(alu_valid), .req(alu_req), .grant(alu_grant),
    .rdata(mem_rdata), .tag(alu_tag)
  );

  vec_reduce_engine u_red (
    .clk, .reset, .start(red_start), .cmd(dispatch_cmd),
    .busy(red_busy), .done(red_done), .done_ack(red_ack),
    .req_valid(red_valid), .req(red_req), .grant(red_grant),
    .rdata(mem_rdata), .tag(red_tag)
  );

  mem_arbiter u_arb (
    .clk, .reset, .host_valid, .alu_valid, .red_valid,
    .host_req, .alu_req, .red_req,
    .host_grant, .alu_grant, .red_grant, .mem_req, .mem_write_en
  );

  std_mem_d1 #(.MEM_SIZE(MEM_SIZE)) u_mem (
    .clk, .reset,
    .addr0(mem_req.addr), .write_data(mem_req.wdata), .write_en(mem_write_en),
    .read_data(mem_rdata), .done(host_wdone)
  );

  assign host_rdata = mem_rdata;   // Valid in the host grant cycle

endmodule

// ==== verification/accel_assertions.sv ====
/* Concurrent protocol checks, bound into the arbiter and the dispatcher.
   Ports that an instance does not need are tied to zero. */
`timescale 1ns/1ps

module accel_assertions
  import accel_pkg::*;
#(
  parameter int DEPTH = 4,
  parameter int CNT_W = 3
) (
  input logic             clk,
  input logic             reset,
  input logic [2:0]       valids,
  input logic [2:0]       grants,
  input logic [CNT_W-1:0] count,
  input logic             cmd_valid,
  input logic             pop,
  input logic             full,
  input logic             any_done,
  input logic             cpl_valid
);

  int             fail_count = 0;   // Read by the testbench at the end
  logic [CNT_W:0] occupancy;        // Commands accepted and not yet dispatched

  always_ff @(posedge clk) begin
    if (reset)
      occupancy <= '0;
    else
      occupancy <= occupancy + cmd_valid - pop;
  end

  one_grant: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grants) && ((grants & ~valids) == 3'b000) &&
    ((valids != 3'b000) == (grants != 3'b000)))
    else begin
      fail_count++;
      $error("memory grant is not one valid requester");
    end

  depth_limit: assert property (@(posedge clk) disable iff (reset)
    (occupancy <= DEPTH) && (occupancy == count))
    else begin
      fail_count++;
      $error("command queue occupancy exceeds its depth or is lost");
    end

  no_push_full: assert property (@(posedge clk) disable iff (reset) !(cmd_valid && full))
    else begin
      fail_count++;
      $error("command pushed while the queue is full");
    end

  cpl_after_done: assert property (@(posedge clk) disable iff (reset) any_done |=> cpl_valid)
    else begin
      fail_count++;
      $error("engine done gave no completion");
    end

  cpl_has_done: assert property (@(posedge clk) disable iff (reset)
    cpl_valid |-> $past(any_done))
    else begin
      fail_count++;
      $error("completion without an engine done");
    end

endmodule

bind mem_arbiter accel_assertions u_arb_chk (
  .clk, .reset, .valids(valid_vec), .grants({red_grant, alu_grant, host_grant}),
  .count('0), .cmd_valid(1'b0), .pop(1'b0), .full(1'b0), .any_done(1'b0),
  .cpl_valid(1'b0)
);

bind cmd_dispatch accel_assertions #(.DEPTH(CMD_DEPTH), .CNT_W(CNT_W)) u_disp_chk (
  .clk, .reset, .valids(3'b000), .grants(3'b000), .count, .cmd_valid, .pop,
  .full, .any_done(alu_done || red_done), .cpl_valid
);

// ==== verification/accel_tb.sv ====
/* Testbench for accel_top: host port, vector and reduction commands,
   credit flow and concurrency, checked against a shadow of the memory. */
`timescale 1ns/1ps

module accel_tb
  import accel_pkg::*;
();

  localparam int MEM_SIZE  = 256;
  localparam int CMD_DEPTH = 4;
  localparam int VLEN      = 16;
  localparam int TIMEOUT   = 20000;   // 5 tests of up to 4 cmds x 16 elems x 9 cycles, plus loads

  logic              clk = 1'b0;
  logic              reset;
  logic              cmd_valid;
  cmd_t              cmd;
  logic              cmd_credit;
  logic              cpl_valid;
  cpl_t              cpl;
  logic              host_valid;
  mem_req_t          host_req;
  logic              host_grant;
  logic [DATA_W-1:0] host_rdata;
  logic              host_wdone;

  logic [DATA_W-1:0] shadow [MEM_SIZE];
  cpl_t              cpl_q [$];
  integer            seed = 32'h99fe_7ad1;
  int                credits;
  int                min_credits;
  int                returned;
  int                cycles = 0;
  int                errors = 0;
  int                test_errors;
  int                tests_run = 0;
  int                assert_fails;
  string             test_name;

  accel_top #(.MEM_SIZE(MEM_SIZE), .CMD_DEPTH(CMD_DEPTH)) u_dut (.*);

  always #4 clk = ~clk;

  // Monitors and timeout --------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!reset && cmd_credit) begin
      credits  = credits + 1;
      returned = returned + 1;
    end
    if (!reset && cpl_valid)
      cpl_q.push_back(cpl);
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Reference model --------------------
  function automatic logic is_red(input opcode_e op);
    return (op == OP_SUM) || (op == OP_MAX);
  endfunction

  function automatic logic [DATA_W-1:0] alu_model(input opcode_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    case (op)
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return a + b;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] reduce_model(input opcode_e op,
                                                     input logic [ADDR_W-1:0] base,
                                                     input int len);
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] x;
    acc = (op == OP_MAX) ? shadow[base] : '0;
    for (int i = 0; i < len; i++) begin
      x = shadow[ADDR_W'(base + ADDR_W'(i))];
      acc = (op == OP_MAX) ? ((x > acc) ? x : acc) : acc + x;
    end
    return acc;
  endfunction

  function automatic cmd_t make_cmd(input opcode_e op, input int tag, input logic [ADDR_W-1:0] a,
                                    input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] d,
                                    input int len);
    return '{op: op, tag: TAG_W'(tag), src_a: a, src_b: b, dst: d, len: LEN_W'(len)};
  endfunction

  // Tasks --------------------
  task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    @(negedge clk);
    host_valid = 1'b1;
    host_req   = '{we: we, addr: addr, wdata: wdata};
    do
      @(posedge clk);
    while (!host_grant);
    rdata = host_rdata;   // Read data valid in the grant cycle
    @(negedge clk);
    host_valid = 1'b0;
    if (we) begin
      @(posedge clk);
      check_value("write done", 1, DATA_W'(host_wdone));
    end
  endtask

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    host_access(1'b1, addr, data, unused);
    shadow[addr] = data;
  endtask

  task automatic check_word(input string what, input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] got;
    host_access(1'b0, addr, '0, got);
    check_value(what, shadow[addr], got);
  endtask

  task automatic load_random(input logic [ADDR_W-1:0] base, input int n);
    for (int i = 0; i < n; i++)
      host_write(ADDR_W'(base + ADDR_W'(i)), $random(seed));
  endtask

  task automatic send_cmd(input cmd_t c);
    if (clk)
      @(negedge clk);   // Align to a falling edge
    while (credits == 0)
      @(negedge clk);   // Wait for a returned credit
    cmd_valid = 1'b1;
    cmd       = c;
    credits   = credits - 1;
    if (credits < min_credits)
      min_credits = credits;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_cpls(input int n);
    while (cpl_q.size() < n)
      @(negedge clk);
  endtask

  task automatic expect_result(input cmd_t c);
    logic [ADDR_W-1:0] d;
    if (is_red(c.op)) begin
      shadow[c.dst] = reduce_model(c.op, c.src_a, c.len);
      check_word("reduction", c.dst);
    end else begin
      for (int i = 0; i < c.len; i++) begin
        d = ADDR_W'(c.dst + ADDR_W'(i));
        shadow[d] = alu_model(c.op, shadow[ADDR_W'(c.src_a + ADDR_W'(i))],
                              shadow[ADDR_W'(c.src_b + ADDR_W'(i))]);
        check_word("element", d);
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    cpl_q.delete();
  endtask

  task automatic end_test();
    tests_run++;
    errors += test_errors;
    $display("%-12s finished with %0d errors", test_name, test_errors);
  endtask

  // Tests --------------------
  task automatic host_readback();
    logic [ADDR_W-1:0] addrs [8];
    start_test("host_rw");
    foreach (addrs[i]) begin
      addrs[i] = ADDR_W'(8'hc0 + ($random(seed) & 32'h3f));
      host_write(addrs[i], $random(seed));
    end
    foreach (addrs[i])
      check_word("read back", addrs[i]);
    end_test();
  endtask

  task automatic vector_ops();
    cmd_t c;
    start_test("vec_ops");
    load_random(8'h00, VLEN);
    load_random(8'h10, VLEN);
    for (int k = 0; k < 4; k++) begin
      cpl_q.delete();
      c = make_cmd(opcode_e'(k), k, 8'h00, 8'h10, 8'h20, VLEN);
      host_write(ADDR_W'(8'h20 + VLEN), $random(seed));   // Guard word past the vector
      send_cmd(c);
      wait_cpls(1);
      check_value("tag", k, DATA_W'(cpl_q[0].tag));
      expect_result(c);
      check_word("past end", ADDR_W'(8'h20 + VLEN));
    end
    end_test();
  endtask

  task automatic reductions();
    cmd_t cs [4];
    start_test("reduce");
    load_random(8'h40, VLEN);
    cs = '{make_cmd(OP_SUM, 0, 8'h40, 8'h00, 8'h60, VLEN),
           make_cmd(OP_MAX, 1, 8'h40, 8'h00, 8'h61, VLEN),
           make_cmd(OP_SUM, 2, 8'h40, 8'h00, 8'h62, 1),
           make_cmd(OP_MAX, 3, 8'h40, 8'h00, 8'h63, 1)};
    foreach (cs[i])
      send_cmd(cs[i]);
    wait_cpls(4);
    foreach (cs[i])
      expect_result(cs[i]);
    end_test();
  endtask

  task automatic credit_flow();
    opcode_e           ops [6] = '{OP_ADD, OP_SUB, OP_SUM, OP_XOR, OP_MAX, OP_AND};
    logic [ADDR_W-1:0] dsts [6] = '{8'h80, 8'h90, 8'h64, 8'ha0, 8'h65, 8'hb0};
    cmd_t              cs [6];
    int                last [2] = '{-1, -1};
    int                seen [6] = '{0, 0, 0, 0, 0, 0};
    int                t;
    start_test("credits");
    returned    = 0;
    min_credits = credits;
    foreach (ops[i])
      cs[i] = make_cmd(ops[i], i, is_red(ops[i]) ? 8'h40 : 8'h00, 8'h10, dsts[i], VLEN);
    foreach (cs[i])
      send_cmd(cs[i]);
    wait_cpls(6);
    check_value("credits used up", 0, min_credits);
    check_value("credits returned", 6, returned);
    check_value("credits owned", CMD_DEPTH, credits);
    foreach (cpl_q[k]) begin
      t = cpl_q[k].tag;
      check_value("engine", DATA_W'(is_red(ops[t])), DATA_W'(cpl_q[k].engine));
      check_value("issue order", 1, DATA_W'(t > last[cpl_q[k].engine]));
      last[cpl_q[k].engine] = t;
      seen[t]++;
    end
    foreach (seen[i])
      check_value("tag count", 1, seen[i]);
    foreach (cs[i])
      expect_result(cs[i]);
    end_test();
  endtask

  task automatic concurrent_run();
    cmd_t alu_cmd;
    cmd_t red_cmd;
    start_test("concurrency");
    load_random(8'he0, VLEN);
    alu_cmd = make_cmd(OP_ADD, 6, 8'h00, 8'h10, 8'hd0, VLEN);
    red_cmd = make_cmd(OP_SUM, 7, 8'h40, 8'h00, 8'h70, VLEN);
    send_cmd(alu_cmd);
    send_cmd(red_cmd);
    for (int i = 0; i < VLEN; i++)
      check_word("host read", ADDR_W'(8'he0 + ADDR_W'(i)));   // While both engines run
    wait_cpls(2);
    expect_result(alu_cmd);
    expect_result(red_cmd);
    end_test();
  endtask

  initial begin
    reset       = 1'b1;
    cmd_valid   = 1'b0;
    cmd         = '0;
    host_valid  = 1'b0;
    host_req    = '0;
    credits     = CMD_DEPTH;
    min_credits = CMD_DEPTH;
    returned    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    host_readback();
    vector_ops();
    reductions();
    credit_flow();
    concurrent_run();
    assert_fails = u_dut.u_arb.u_arb_chk.fail_count + u_dut.u_dispatch.u_disp_chk.fail_count;
    $display("%0d tests run, %0d check errors, %0d assertion errors",
             tests_run, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
src/accel_pkg.sv
src/std_mem_d1.sv
src/mem_arbiter.sv
src/vec_alu_engine.sv
src/vec_reduce_engine.sv
src/cmd_dispatch.sv
src/accel_top.sv
verification/accel_assertions.sv
verification/accel_tb.sv
